// ==== design/mips_mem_pkg.sv ====
package mips_mem_pkg;

    // MIPS primary opcode values for the memory instructions.
    typedef enum logic [5:0] {
        OP_NOP = 6'h00,
        OP_LB  = 6'h20,
        OP_LH  = 6'h21,
        OP_LW  = 6'h23,
        OP_LBU = 6'h24,
        OP_LHU = 6'h25,
        OP_SB  = 6'h28,
        OP_SH  = 6'h29,
        OP_SW  = 6'h2b
    } op_t;

    // Bits 7 to 2 come from earlier stages and pass through untouched.
    typedef logic [7:0] except_t;

    localparam int EXC_ADES = 0; // Store address error.
    localparam int EXC_ADEL = 1; // Load address error.

    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = 8;

    // Request from execute, as it sits in the EX/MEM register.
    typedef struct packed {
        logic        valid;
        op_t         op;
        logic        en;
        logic [31:0] addr;
        logic [31:0] wdata;
        except_t     except_in;
    } mem_req_t;

    typedef struct packed {
        logic        en;
        logic [3:0]  wen;
        logic [31:0] addr;
        logic [31:0] wdata;
    } ram_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
        except_t     except;
    } mem_res_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
        except_t     except;
        logic        exc_taken; // Valid slot with at least one cause set.
    } wb_t;

endpackage

// ==== design/ex_mem_reg.sv ====
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic                   clk,
    input  logic                   rst,
    input  mips_mem_pkg::mem_req_t req,
    output mips_mem_pkg::mem_req_t q
);

    import mips_mem_pkg::*;

    always_ff @(posedge clk) begin
        q <= req;
        if (rst) begin
            q.valid <= 1'b0; // Empty slot after reset.
            q.en    <= 1'b0; // Keeps stale stores out of the RAM.
        end
    end

    // The execute stage may only enable an access on a live slot, so an
    // enabled request in MEM always carries its valid bit.
    assert property (@(posedge clk) disable iff (rst) q.en |-> q.valid)
        else $error("ex_mem_reg: access enabled on an empty slot");

    // Enabled operations must be real memory opcodes.
    assert property (@(posedge clk) disable iff (rst)
        q.en |-> q.op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW})
        else $error("ex_mem_reg: access enabled for a non-memory opcode");

endmodule

// ==== design/mem_access.sv ====
`timescale 1ns/1ps

module mem_access (
    input  mips_mem_pkg::mem_req_t mreq,
    input  logic [31:0]            ram_rdata,
    output mips_mem_pkg::ram_req_t ram,
    output mips_mem_pkg::mem_res_t res
);

    import mips_mem_pkg::*;

    logic        ades;
    logic        adel;
    logic        is_load;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    logic [3:0]  wen;
    logic [31:0] wdata;
    logic [31:0] rdata;

    // Byte and halfword picked out of the word by the low address bits.
    assign lane_b = ram_rdata[8*mreq.addr[1:0] +: 8];
    assign lane_h = mreq.addr[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    assign is_load = mreq.op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};

    always_comb begin
        ades  = 1'b0;
        adel  = 1'b0;
        wen   = 4'b0000;
        wdata = mreq.wdata;
        rdata = 32'h0; // Faulting loads and non-loads return zero.

        case (mreq.op)
            OP_LW: begin
                if (mreq.addr[1:0] != 2'b00) begin
                    adel = 1'b1;
                end else begin
                    rdata = ram_rdata;
                end
            end
            OP_LH: begin
                if (mreq.addr[0] != 1'b0) begin
                    adel = 1'b1;
                end else begin
                    rdata = {{16{lane_h[15]}}, lane_h};
                end
            end
            OP_LHU: begin
                if (mreq.addr[0] != 1'b0) begin
                    adel = 1'b1;
                end else begin
                    rdata = {16'h0, lane_h};
                end
            end
            OP_LB: begin
                rdata = {{24{lane_b[7]}}, lane_b};
            end
            OP_LBU: begin
                rdata = {24'h0, lane_b};
            end
            OP_SW: begin
                if (mreq.addr[1:0] != 2'b00) begin
                    ades = 1'b1;
                end else begin
                    wen = 4'b1111;
                end
            end
            OP_SH: begin
                wdata = {2{mreq.wdata[15:0]}};
                if (mreq.addr[0] != 1'b0) begin
                    ades = 1'b1;
                end else if (mreq.addr[1]) begin
                    wen = 4'b1100;
                end else begin
                    wen = 4'b0011;
                end
            end
            OP_SB: begin
                wdata = {4{mreq.wdata[7:0]}};
                wen   = 4'b0001 << mreq.addr[1:0]; // One lane per byte offset.
            end
            default: begin
                wen = 4'b0000;
            end
        endcase
    end

    always_comb begin
        ram.en    = mreq.en;
        ram.wen   = wen;
        ram.addr  = mreq.addr;
        ram.wdata = wdata;
    end

    always_comb begin
        res.valid           = mreq.valid;
        res.rdata           = rdata;
        res.except          = mreq.except_in; // Upper causes ride through.
        res.except[EXC_ADEL] = adel;
        res.except[EXC_ADES] = ades;
    end

    // A single operation is either a load or a store, so at most one
    // address error can be reported for it.
    always_comb begin
        assert final (!(ades && adel))
            else $error("mem_access: adel and ades raised together");
    end

    // Loads must never disturb the RAM.
    always_comb begin
        assert final (!is_load || ram.wen == 4'b0000)
            else $error("mem_access: byte enables active on a load");
    end

endmodule

// ==== design/data_ram.sv ====
`timescale 1ns/1ps

module data_ram (
    input  logic                   clk,
    input  mips_mem_pkg::ram_req_t ram,
    output logic [31:0]            rdata
);

    import mips_mem_pkg::*;

    logic [31:0]       mem [RAM_WORDS];
    logic [RAM_AW-1:0] waddr;

    // Word index. Byte offset and the upper address bits are ignored.
    assign waddr = ram.addr[RAM_AW+1:2];

    // Asynchronous read lets a load see a store from the previous edge.
    assign rdata = mem[waddr];

    always_ff @(posedge clk) begin
        if (ram.en) begin
            for (int i = 0; i < 4; i++) begin
                if (ram.wen[i]) begin
                    mem[waddr][8*i +: 8] <= ram.wdata[8*i +: 8];
                end
            end
        end
    end

    // Only checked once enables are known, since the RAM has no reset.
    assert property (@(posedge clk) !$isunknown(ram.en) && ram.en |-> !$isunknown(waddr))
        else $error("data_ram: unknown word address on an enabled access");

endmodule

// ==== design/mem_wb_reg.sv ====
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic                   clk,
    input  logic                   rst,
    input  mips_mem_pkg::mem_res_t res,
    output mips_mem_pkg::wb_t      wb
);

    import mips_mem_pkg::*;

    logic exc_any;

    assign exc_any = (res.except != except_t'(0));

    always_ff @(posedge clk) begin
        wb.rdata     <= res.rdata;
        wb.except    <= res.except;
        wb.valid     <= res.valid;
        wb.exc_taken <= res.valid && exc_any; // Empty slots never trap.
        if (rst) begin
            wb.valid     <= 1'b0;
            wb.exc_taken <= 1'b0;
        end
    end

    // A faulting load hands zero data to writeback.
    assert property (@(posedge clk) disable iff (rst)
        res.valid && res.except[EXC_ADEL] |=> wb.rdata == 32'h0)
        else $error("mem_wb_reg: load address error returned nonzero data");

endmodule

// ==== design/mem_stage_top.sv ====
`timescale 1ns/1ps

module mem_stage_top (
    input  logic                   clk,
    input  logic                   rst,
    input  mips_mem_pkg::mem_req_t req,
    output mips_mem_pkg::wb_t      wb
);

    import mips_mem_pkg::*;

    mem_req_t    mreq;
    ram_req_t    ram;
    mem_res_t    res;
    logic [31:0] ram_rdata;

    ex_mem_reg u_ex_mem (
        .clk (clk),
        .rst (rst),
        .req (req),
        .q   (mreq)
    );

    // Combinational, so the RAM sees this cycle's request directly.
    mem_access u_mem_access (
        .mreq      (mreq),
        .ram_rdata (ram_rdata),
        .ram       (ram),
        .res       (res)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .ram   (ram),
        .rdata (ram_rdata)
    );

    mem_wb_reg u_mem_wb (
        .clk (clk),
        .rst (rst),
        .res (res),
        .wb  (wb)
    );

endmodule

// ==== bench/mem_stage_tb.sv ====
`timescale 1ns/1ps

module mem_stage_tb;

    import mips_mem_pkg::*;

    typedef struct packed {
        logic        valid;
        op_t         op;
        logic        en;
        logic [31:0] addr;
        logic [31:0] wdata;
        except_t     except_in;
        logic        rnd; // Take wdata from the LFSR when the entry is applied.
    } entry_t;

    logic        clk;
    logic        rst;
    mem_req_t    req;
    wb_t         wb;

    entry_t      table_q [$];
    wb_t         exp_q [$];
    logic [31:0] model_mem [RAM_WORDS];
    logic [31:0] lfsr_state = 32'd53;
    int          cycles = 0;

    mem_stage_top dut0 (
        .clk (clk),
        .rst (rst),
        .req (req),
        .wb  (wb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_stop(string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_data(string name, logic [31:0] want, logic [31:0] got);
        if (got !== want)
            fail_stop($sformatf("[FAIL] t=%0t %s expected %08h got %08h", $time, name, want, got));
    endtask

    task automatic check_except(string name, except_t want, except_t got);
        if (got !== want)
            fail_stop($sformatf("[FAIL] t=%0t %s expected %02h got %02h", $time, name, want, got));
    endtask

    task automatic check_valid(string name, logic want, logic got);
        if (got !== want)
            fail_stop($sformatf("[FAIL] t=%0t %s expected %0b got %0b", $time, name, want, got));
    endtask

    // Galois form of x^32 + x^22 + x^2 + x + 1, shifting right.
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] v;
        v = 32'h0;
        for (int k = 0; k < 32; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]}; // One step for every bit taken.
        end
        return v;
    endfunction

    // Expected writeback for one operation, and the memory update it causes.
    function automatic wb_t model_apply(entry_t e);
        wb_t         r;
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        logic        adel;
        logic        ades;
        int          idx;
        idx     = int'(e.addr[RAM_AW+1:2]);
        word    = model_mem[idx];
        adel    = 1'b0;
        ades    = 1'b0;
        r.rdata = 32'h0;
        case (e.op)
            OP_LB, OP_LBU: begin
                b = 8'(word >> (8 * e.addr[1:0]));
                if (e.op == OP_LB)
                    r.rdata = 32'($signed(b));
                else
                    r.rdata = 32'(b);
            end
            OP_LH, OP_LHU: begin
                if (e.addr[0]) begin
                    adel = 1'b1;
                end else begin
                    h = 16'(word >> (16 * e.addr[1]));
                    if (e.op == OP_LH)
                        r.rdata = 32'($signed(h));
                    else
                        r.rdata = 32'(h);
                end
            end
            OP_LW: begin
                if (e.addr[1:0] != 2'b00)
                    adel = 1'b1;
                else
                    r.rdata = word;
            end
            OP_SW: begin
                if (e.addr[1:0] != 2'b00)
                    ades = 1'b1;
                else if (e.en)
                    word = e.wdata;
            end
            OP_SH: begin
                if (e.addr[0])
                    ades = 1'b1;
                else if (e.en && e.addr[1])
                    word[31:16] = e.wdata[15:0];
                else if (e.en)
                    word[15:0] = e.wdata[15:0];
            end
            OP_SB: begin
                for (int k = 0; k < 4; k++) begin
                    if (e.en && k == int'(e.addr[1:0]))
                        word[8*k +: 8] = e.wdata[7:0];
                end
            end
            default: ;
        endcase
        model_mem[idx] = word;
        r.valid     = e.valid;
        r.except    = {e.except_in[7:2], adel, ades};
        r.exc_taken = e.valid && (r.except != 8'h00);
        return r;
    endfunction

    task automatic add_entry(logic valid, op_t op, logic en, logic [31:0] addr,
                             logic [31:0] wdata, except_t exc, logic rnd);
        table_q.push_back('{valid: valid, op: op, en: en, addr: addr, wdata: wdata,
                            except_in: exc, rnd: rnd});
    endtask

    task automatic build_table();
        for (int w = 0; w < 8; w++)
            add_entry(1'b1, OP_SW, 1'b1, 32'(w * 4), 32'h0, 8'h00, 1'b1);
        for (int w = 0; w < 8; w++)
            add_entry(1'b1, OP_LW, 1'b1, 32'(w * 4), 32'h0, 8'h00, 1'b0);
        // Partial stores into a known word; the upper wdata bits must be ignored.
        add_entry(1'b1, OP_SW, 1'b1, 32'h20, 32'h1122_3344, 8'h00, 1'b0);
        add_entry(1'b1, OP_SB, 1'b1, 32'h21, 32'h0000_00aa, 8'h00, 1'b0);
        add_entry(1'b1, OP_SH, 1'b1, 32'h22, 32'h0000_beef, 8'h00, 1'b0);
        add_entry(1'b1, OP_SB, 1'b1, 32'h20, 32'hffff_ff5a, 8'h00, 1'b0);
        add_entry(1'b1, OP_LW, 1'b1, 32'h20, 32'h0, 8'h00, 1'b0);
        add_entry(1'b1, OP_SW, 1'b1, 32'h24, 32'h80f1_a2ff, 8'h00, 1'b0);
        add_entry(1'b1, OP_SW, 1'b1, 32'h28, 32'h7f01_6e35, 8'h00, 1'b0);
        for (int a = 0; a < 8; a++) begin
            add_entry(1'b1, OP_LB, 1'b1, 32'h24 + a, 32'h0, 8'h00, 1'b0);
            add_entry(1'b1, OP_LBU, 1'b1, 32'h24 + a, 32'h0, 8'h00, 1'b0);
            if (a % 2 == 0) begin
                add_entry(1'b1, OP_LH, 1'b1, 32'h24 + a, 32'h0, 8'h00, 1'b0);
                add_entry(1'b1, OP_LHU, 1'b1, 32'h24 + a, 32'h0, 8'h00, 1'b0);
            end
        end
        add_entry(1'b1, OP_LW, 1'b1, 32'h25, 32'h0, 8'h00, 1'b0); // Address errors.
        add_entry(1'b1, OP_LW, 1'b1, 32'h26, 32'h0, 8'h00, 1'b0);
        add_entry(1'b1, OP_LH, 1'b1, 32'h27, 32'h0, 8'h00, 1'b0);
        add_entry(1'b1, OP_LHU, 1'b1, 32'h29, 32'h0, 8'h00, 1'b0);
        add_entry(1'b1, OP_SW, 1'b1, 32'h27, 32'h0, 8'h00, 1'b1);
        add_entry(1'b1, OP_SH, 1'b1, 32'h29, 32'h0, 8'h00, 1'b1);
        add_entry(1'b1, OP_LW, 1'b1, 32'h24, 32'h0, 8'h00, 1'b0);
        add_entry(1'b1, OP_LW, 1'b1, 32'h28, 32'h0, 8'h00, 1'b0);
        // Causes from earlier stages ride along with legal accesses too.
        add_entry(1'b1, OP_LW, 1'b1, 32'h24, 32'h0, 8'ha4, 1'b0);
        add_entry(1'b1, OP_SW, 1'b1, 32'h2c, 32'h0bad_f00d, 8'h08, 1'b0);
        add_entry(1'b1, OP_LB, 1'b1, 32'h2d, 32'h0, 8'hff, 1'b0);
        add_entry(1'b1, OP_LH, 1'b1, 32'h2d, 32'h0, 8'h40, 1'b0);
        add_entry(1'b1, OP_LW, 1'b1, 32'h2c, 32'h0, 8'h00, 1'b0);
        add_entry(1'b0, OP_NOP, 1'b0, 32'h2c, 32'hffff_ffff, 8'hfc, 1'b0);
        add_entry(1'b1, OP_SW, 1'b0, 32'h2c, 32'hdead_beef, 8'h00, 1'b0);
        add_entry(1'b1, OP_LW, 1'b1, 32'h2c, 32'h0, 8'h00, 1'b0);
        add_entry(1'b0, OP_NOP, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0); // Drain.
        add_entry(1'b0, OP_NOP, 1'b0, 32'h0, 32'h0, 8'h00, 1'b0);
    endtask

    task automatic check_slot(wb_t want);
        check_valid("wb.valid", want.valid, wb.valid);
        check_valid("wb.exc_taken", want.exc_taken, wb.exc_taken);
        check_data("wb.rdata", want.rdata, wb.rdata);
        check_except("wb.except", want.except, wb.except);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > table_q.size() + 20)
            fail_stop($sformatf("Timeout: the run did not finish within %0d cycles", cycles));
    end

    initial begin
        entry_t e;
        wb_t    want;
        rst = 1'b1;
        // A live slot with causes set, which reset has to clear in both registers.
        req = '{valid: 1'b1, op: OP_NOP, en: 1'b0, addr: 32'h0, wdata: 32'h0,
                except_in: 8'hfc};
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        req <= '0;
        @(negedge clk);
        check_valid("wb.valid", 1'b0, wb.valid);
        check_valid("wb.exc_taken", 1'b0, wb.exc_taken);
        foreach (table_q[i]) begin
            e = table_q[i];
            if (e.rnd)
                e.wdata = random_word();
            @(posedge clk);
            req <= '{valid: e.valid, op: e.op, en: e.en, addr: e.addr, wdata: e.wdata,
                     except_in: e.except_in};
            exp_q.push_back(model_apply(e));
            @(negedge clk);
            if (exp_q.size() == 3) begin // The oldest slot has now reached writeback.
                want = exp_q.pop_front();
                check_slot(want);
            end else if (i == 0) begin // Slot that sat in MEM during reset.
                check_valid("wb.valid", 1'b0, wb.valid);
                check_valid("wb.exc_taken", 1'b0, wb.exc_taken);
            end
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== list.f ====
design/mips_mem_pkg.sv
design/ex_mem_reg.sv
design/mem_access.sv
design/data_ram.sv
design/mem_wb_reg.sv
design/mem_stage_top.sv
bench/mem_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
TOP       := mem_stage_tb
FILELIST  := list.f
BUILD     := obj_dir
SOURCES   := $(shell grep '\.sv$$' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)
